// ==== src.f ====
hdl/stepper_pkg.sv
hdl/reg_bus_slave.sv
hdl/motion_profile.sv
hdl/phase_driver.sv
hdl/stepper_top.sv
verif/stepper_props.sv
verif/tb_stepper.sv

// ==== Bender.yml ====
package:
  name: stepper_ctrl

sources:
  # rtl, package first
  - hdl/stepper_pkg.sv
  - hdl/reg_bus_slave.sv
  - hdl/motion_profile.sv
  - hdl/phase_driver.sv
  - hdl/stepper_top.sv
  # verification
  - target: test
    files:
      - verif/stepper_props.sv
      - verif/tb_stepper.sv

// ==== verif/tb_stepper.sv ====
module tb_stepper;
    import stepper_pkg::*;

    localparam logic [DATA_W-1:0] CORE_ID  = 32'h5354_0039;
    localparam int                MS_W     = 8;
    localparam int                PERIOD   = 1 << MS_W;
    localparam int                ACK_WAIT = 20;

    // coil pair (a,b) per quadrant
    localparam logic [1:0] GRAY_AB [4] = '{2'b00, 2'b10, 2'b11, 2'b01};

    logic              clk;
    logic              reset;
    logic              req;
    bus_req_t          bus_req;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              out_en;
    logic              out_a;
    logic              out_b;
    logic [15:0]       lfsr_q;
    int unsigned       cycle_cnt;

    stepper_top #(
        .CORE_ID         (CORE_ID),
        .MICROSTEP_WIDTH (MS_W)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req),
        .bus_req_i (bus_req),
        .ack_o     (ack),
        .rdata_o   (rdata),
        .out_en_o  (out_en),
        .out_a_o   (out_a),
        .out_b_o   (out_b)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dut_i.props_i.fail_count != 0) begin
            fail_run("a handshake or coil assertion in stepper_props failed");
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
        assert (act === exp)
            else fail_run($sformatf("ERROR at time %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    // stepped once per bit
    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] r;
        logic              fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[DATA_W-2:0], fb};
        end
        return r;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level) begin
            if (n == ACK_WAIT) begin
                fail_run($sformatf("timeout waiting for ack_o to go %0b", level));
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic we,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] data);
        @(posedge clk);
        bus_req.addr  <= addr;
        bus_req.we    <= we;
        bus_req.wdata <= wdata;
        req           <= 1'b1;
        @(posedge clk);
        wait_ack(1'b1);
        data = rdata;
        req <= 1'b0;
        @(posedge clk);
        wait_ack(1'b0);
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] dummy_data;
        bus_access(addr, 1'b1, wdata, dummy_data);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        bus_access(addr, 1'b0, '0, data);
    endtask

    task automatic expect_reg(input logic [ADDR_W-1:0] addr, input string name,
                              input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] data;
        read_reg(addr, data);
        check_eq(name, exp, data);
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] pos_a;
        logic [DATA_W-1:0] pos_b;
        logic [DATA_W-1:0] spd;
        logic [1:0]        q;
        logic [7:0]        frac;
        int                max_acc;
        int                max_speed;
        int                speed;
        int                last_speed;
        int                diff;
        int                n_upd;
        int                hits;
        int unsigned       last_cycle;

        reset     = 1'b1;
        req       = 1'b0;
        bus_req   = '0;
        lfsr_q    = 16'd57;
        cycle_cnt = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // values after reset
        check_eq("{out_en_o, out_a_o, out_b_o}", 3'b000, {out_en, out_a, out_b});
        expect_reg(ADR_CORE_ID, "core_id", CORE_ID);
        expect_reg(ADR_CONTROL, "control", 32'd0);
        expect_reg(ADR_MAX_ACC, "max_acc", 32'd100);
        expect_reg(ADR_MAX_SPEED, "max_speed", 32'd100);

        // register readback
        for (int r = 0; r < 4; r++) begin
            value = rand_bits(4);
            write_reg(ADR_CONTROL, value);
            expect_reg(ADR_CONTROL, "control", value);
            value = rand_bits(16);
            write_reg(ADR_MAX_ACC, value);
            expect_reg(ADR_MAX_ACC, "max_acc", value);
            value = rand_bits(16);
            write_reg(ADR_MAX_SPEED, value);
            expect_reg(ADR_MAX_SPEED, "max_speed", value);
        end
        for (int a = 0; a < 16; a++) begin
            if (!(4'(a) inside {ADR_CORE_ID, ADR_CONTROL, ADR_CUR_ACC, ADR_CUR_SPEED,
                                ADR_CUR_POS, ADR_MAX_ACC, ADR_MAX_SPEED})) begin
                expect_reg(4'(a), "unmapped rdata_o", 32'd0);
            end
        end

        // speed clamping against max_speed and max_acc
        for (int r = 0; r < 3; r++) begin
            max_acc   = rand_bits(10);
            max_speed = rand_bits(12);
            write_reg(ADR_CONTROL, 32'h0);
            write_reg(ADR_MAX_ACC, max_acc);
            write_reg(ADR_MAX_SPEED, max_speed);
            write_reg(ADR_CUR_SPEED, 32'h0);
            write_reg(ADR_CUR_ACC, rand_bits(16));
            write_reg(ADR_CONTROL, 32'h1);
            for (int k = 0; k < 5; k++) begin
                idle(rand_bits(9));
                read_reg(ADR_CUR_SPEED, value);
                speed = $signed(value);
                assert (speed <= max_speed && speed >= -max_speed)
                    else fail_run($sformatf("cur_speed %0d outside the limit of +-%0d",
                                            speed, max_speed));
                if (k > 0) begin
                    n_upd = int'((cycle_cnt - last_cycle) / PERIOD) + 1;
                    diff  = speed - last_speed;
                    if (diff < 0) begin
                        diff = -diff;
                    end
                    assert (diff <= n_upd * max_acc)
                        else fail_run($sformatf("cur_speed moved by %0d in %0d updates",
                                                diff, n_upd));
                end
                last_speed = speed;
                last_cycle = cycle_cnt;
            end
        end

        // position integration at constant speed
        write_reg(ADR_CONTROL, 32'h0);
        write_reg(ADR_MAX_ACC, 32'h0);
        write_reg(ADR_MAX_SPEED, 32'hFFFF);
        write_reg(ADR_CUR_ACC, 32'h0);
        spd = rand_bits(12) | 32'h1;
        write_reg(ADR_CUR_SPEED, spd);
        write_reg(ADR_CUR_POS, rand_bits(24));
        write_reg(ADR_CONTROL, 32'h1);
        read_reg(ADR_CUR_POS, pos_a);
        idle(700 + rand_bits(8));
        read_reg(ADR_CUR_POS, pos_b);
        assert ((pos_b - pos_a) % spd == 0)
            else fail_run($sformatf("cur_pos step %0d is not a multiple of speed %0d",
                                    pos_b - pos_a, spd));

        // disabled motor holds position and coils
        write_reg(ADR_CONTROL, 32'h0);
        read_reg(ADR_CUR_POS, pos_a);
        for (int i = 0; i < 600; i++) begin
            @(posedge clk);
            check_eq("{out_en_o, out_a_o, out_b_o}", 3'b000, {out_en, out_a, out_b});
        end
        expect_reg(ADR_CUR_POS, "cur_pos", pos_a);

        // full steps
        write_reg(ADR_CUR_SPEED, 32'h0);
        write_reg(ADR_CONTROL, 32'h3);
        for (int k = 0; k < 4; k++) begin
            write_reg(ADR_CUR_POS, {14'(rand_bits(14)), 2'(k), 16'(rand_bits(16))});
            idle(3 + rand_bits(8));
            check_eq("{out_a_o, out_b_o}", GRAY_AB[k], {out_a, out_b});
        end

        // microstep duty over one PWM period, nanostep off
        write_reg(ADR_CONTROL, 32'h5);
        for (int r = 0; r < 3; r++) begin
            frac = rand_bits(8);
            q    = rand_bits(2);
            write_reg(ADR_CUR_POS, {14'(rand_bits(14)), q, frac, 8'(rand_bits(8))});
            idle(PERIOD + 20);
            hits = 0;
            for (int i = 0; i < PERIOD; i++) begin
                @(posedge clk);
                if ({out_a, out_b} == GRAY_AB[q + 2'd1]) begin
                    hits++;
                end else begin
                    check_eq("{out_a_o, out_b_o}", GRAY_AB[q], {out_a, out_b});
                end
            end
            check_eq("next quadrant cycles of {out_a_o, out_b_o}", frac, hits);
        end

        if (dut_i.props_i.fail_count != 0) begin
            fail_run("a handshake or coil assertion in stepper_props failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== verif/stepper_props.sv ====
module stepper_props (
    input logic                           clk,
    input logic                           reset,
    input logic                           req_i,
    input logic                           ack_o,
    input logic [stepper_pkg::DATA_W-1:0] rdata_o,
    input logic                           out_en_o,
    input logic                           out_a_o,
    input logic                           out_b_o
);

    int unsigned fail_count;

    initial fail_count = 0;

    // --------------------------------------------------
    // four-phase handshake
    // --------------------------------------------------
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack_o) |-> req_i && $past(req_i))
        else begin
            $error("ack_o rose while req_i was low");
            fail_count++;
        end

    ack_held: assert property (@(posedge clk) disable iff (reset)
        ack_o && req_i |=> ack_o)
        else begin
            $error("ack_o dropped before req_i fell");
            fail_count++;
        end

    rdata_stable: assert property (@(posedge clk) disable iff (reset)
        ack_o && $past(ack_o) |-> $stable(rdata_o))
        else begin
            $error("rdata_o changed while ack_o was high");
            fail_count++;
        end

    ack_released: assert property (@(posedge clk) disable iff (reset)
        $fell(req_i) |-> ##[0:2] !ack_o)
        else begin
            $error("ack_o still high two cycles after req_i fell");
            fail_count++;
        end

    // coils follow enable one cycle late
    coils_off: assert property (@(posedge clk) disable iff (reset)
        !out_en_o && $past(!out_en_o) |-> !out_a_o && !out_b_o)
        else begin
            $error("coil output active while out_en_o is low");
            fail_count++;
        end

endmodule

bind stepper_top stepper_props props_i (
    .clk      (clk),
    .reset    (reset),
    .req_i    (req_i),
    .ack_o    (ack_o),
    .rdata_o  (rdata_o),
    .out_en_o (out_en_o),
    .out_a_o  (out_a_o),
    .out_b_o  (out_b_o)
);

// ==== hdl/stepper_top.sv ====
module stepper_top #(
    parameter logic [stepper_pkg::DATA_W-1:0] CORE_ID         = 32'h5354_4550,
    parameter int                             Q_WIDTH         = stepper_pkg::Q_W,
    parameter int                             MICROSTEP_WIDTH = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_i,
    input  stepper_pkg::bus_req_t          bus_req_i,
    output logic                           ack_o,
    output logic [stepper_pkg::DATA_W-1:0] rdata_o,
    output logic                           out_en_o,
    output logic                           out_a_o,
    output logic                           out_b_o
);
    import stepper_pkg::*;

    ctrl_t           ctrl;
    motion_wr_t      motion_wr;
    motion_state_t   motion_state;
    logic [Q_W-1:0]  max_acc;
    logic [Q_W-1:0]  max_speed;
    logic            update;

    reg_bus_slave #(
        .CORE_ID     (CORE_ID)
    ) bus_i (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req_i),
        .bus_req_i   (bus_req_i),
        .state_i     (motion_state),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .ctrl_o      (ctrl),
        .max_acc_o   (max_acc),
        .max_speed_o (max_speed),
        .wr_o        (motion_wr)
    );

    motion_profile #(
        .Q_WIDTH     (Q_WIDTH)
    ) profile_i (
        .clk         (clk),
        .reset       (reset),
        .enable_i    (ctrl.enable),
        .max_acc_i   (max_acc),
        .max_speed_i (max_speed),
        .wr_i        (motion_wr),
        .update_i    (update),
        .state_o     (motion_state)
    );

    // driver sees only the quadrant and fraction bits
    phase_driver #(
        .Q_WIDTH         (Q_WIDTH),
        .MICROSTEP_WIDTH (MICROSTEP_WIDTH)
    ) driver_i (
        .clk             (clk),
        .reset           (reset),
        .ctrl_i          (ctrl),
        .phase_i         (motion_state.cur_pos[Q_WIDTH+1:0]),
        .update_o        (update),
        .out_a_o         (out_a_o),
        .out_b_o         (out_b_o)
    );

    assign out_en_o = ctrl.enable;

endmodule

// ==== hdl/phase_driver.sv ====
module phase_driver #(
    parameter int Q_WIDTH         = stepper_pkg::Q_W,
    parameter int MICROSTEP_WIDTH = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  stepper_pkg::ctrl_t ctrl_i,
    input  logic [Q_WIDTH+1:0] phase_i,
    output logic               update_o,
    output logic               out_a_o,
    output logic               out_b_o
);
    import stepper_pkg::*;

    // fraction bits below the microstep resolution
    localparam int NANO_W = Q_WIDTH - MICROSTEP_WIDTH;

    logic [MICROSTEP_WIDTH-1:0] cnt_q;
    logic                       period_end;
    logic [NANO_W-1:0]          nano_acc_q;
    logic                       carry_q;
    logic [1:0]                 quad;
    logic [MICROSTEP_WIDTH-1:0] frac;
    logic [NANO_W-1:0]          nano;
    logic [MICROSTEP_WIDTH:0]   thresh;
    logic                       show_next;
    logic [1:0]                 ab;

    // coil polarity (a,b) per quadrant
    function automatic logic [1:0] gray_ab(input logic [1:0] q);
        case (q)
            2'd0:    return 2'b00;
            2'd1:    return 2'b10;
            2'd2:    return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    assign quad       = phase_i[Q_WIDTH+1:Q_WIDTH];
    assign frac       = phase_i[Q_WIDTH-1 -: MICROSTEP_WIDTH];
    assign nano       = phase_i[NANO_W-1:0];
    assign period_end = (cnt_q == '1);

    // --------------------------------------------------
    // PWM period and update pulse
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q    <= '0;
            update_o <= 1'b0;
        end else begin
            cnt_q    <= cnt_q + 1'b1;
            update_o <= ctrl_i.async_update | period_end;
        end
    end

    // nanostep dither with one carry decision per period
    always_ff @(posedge clk) begin
        if (reset) begin
            nano_acc_q <= '0;
            carry_q    <= 1'b0;
        end else if (period_end) begin
            if (ctrl_i.nanostep_dis) begin
                nano_acc_q <= '0;
                carry_q    <= 1'b0;
            end else begin
                {carry_q, nano_acc_q} <= nano_acc_q + nano;
            end
        end
    end

    assign thresh    = {1'b0, frac} + carry_q;
    assign show_next = ({1'b0, cnt_q} < thresh);

    always_comb begin
        if (ctrl_i.microstep_dis || !show_next) begin
            ab = gray_ab(quad);
        end else begin
            ab = gray_ab(quad + 2'd1);
        end
    end

    // --------------------------------------------------
    // coil outputs
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || !ctrl_i.enable) begin
            out_a_o <= 1'b0;
            out_b_o <= 1'b0;
        end else begin
            out_a_o <= ab[1];
            out_b_o <= ab[0];
        end
    end

endmodule

// ==== hdl/motion_profile.sv ====
module motion_profile #(
    parameter int Q_WIDTH = stepper_pkg::Q_W
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable_i,
    input  logic [Q_WIDTH-1:0]         max_acc_i,
    input  logic [Q_WIDTH-1:0]         max_speed_i,
    input  stepper_pkg::motion_wr_t    wr_i,
    input  logic                       update_i,
    output stepper_pkg::motion_state_t state_o
);
    import stepper_pkg::*;

    // largest positive signed speed
    localparam logic [Q_WIDTH-1:0] SPEED_TOP = {1'b0, {(Q_WIDTH-1){1'b1}}};

    logic signed [Q_WIDTH-1:0] cur_acc_q;
    logic signed [Q_WIDTH-1:0] cur_speed_q;
    logic signed [POS_W-1:0]   cur_pos_q;
    logic signed [Q_WIDTH-1:0] acc_q;
    logic signed [Q_WIDTH-1:0] speed_q;
    logic signed [Q_WIDTH:0]   max_acc_s;
    logic signed [Q_WIDTH:0]   lim_speed_s;
    logic signed [Q_WIDTH+1:0] speed_sum;

    assign max_acc_s   = {1'b0, max_acc_i};
    // keep the limit inside the signed speed range
    assign lim_speed_s = (max_speed_i > SPEED_TOP) ? {1'b0, SPEED_TOP} : {1'b0, max_speed_i};
    assign speed_sum   = cur_speed_q + acc_q;

    // --------------------------------------------------
    // clamp pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q   <= '0;
            speed_q <= '0;
        end else begin
            if (cur_acc_q > max_acc_s) begin
                acc_q <= max_acc_s[Q_WIDTH-1:0];
            end else if (cur_acc_q < -max_acc_s) begin
                acc_q <= -max_acc_s[Q_WIDTH-1:0];
            end else begin
                acc_q <= cur_acc_q;
            end

            if (speed_sum > lim_speed_s) begin
                speed_q <= lim_speed_s[Q_WIDTH-1:0];
            end else if (speed_sum < -lim_speed_s) begin
                speed_q <= -lim_speed_s[Q_WIDTH-1:0];
            end else begin
                speed_q <= speed_sum[Q_WIDTH-1:0];
            end
        end
    end

    // integration where host writes take priority
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_acc_q   <= '0;
            cur_speed_q <= '0;
            cur_pos_q   <= '0;
        end else begin
            if (update_i && enable_i) begin
                cur_pos_q   <= cur_pos_q + speed_q;
                cur_speed_q <= speed_q;
            end
            if (wr_i.wr_acc)   cur_acc_q   <= wr_i.acc;
            if (wr_i.wr_speed) cur_speed_q <= wr_i.speed;
            if (wr_i.wr_pos)   cur_pos_q   <= wr_i.pos;
        end
    end

    assign state_o.cur_acc   = cur_acc_q;
    assign state_o.cur_speed = cur_speed_q;
    assign state_o.cur_pos   = cur_pos_q;

endmodule

// ==== hdl/reg_bus_slave.sv ====
module reg_bus_slave #(
    parameter logic [stepper_pkg::DATA_W-1:0] CORE_ID = 32'h5354_4550
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_i,
    input  stepper_pkg::bus_req_t              bus_req_i,
    input  stepper_pkg::motion_state_t         state_i,
    output logic                               ack_o,
    output logic [stepper_pkg::DATA_W-1:0]     rdata_o,
    output stepper_pkg::ctrl_t                 ctrl_o,
    output logic [stepper_pkg::Q_W-1:0]        max_acc_o,
    output logic [stepper_pkg::Q_W-1:0]        max_speed_o,
    output stepper_pkg::motion_wr_t            wr_o
);
    import stepper_pkg::*;

    logic              ack_q;
    logic              accept;
    logic              wr_en;
    logic [DATA_W-1:0] rdata_next;

    // new request seen while idle
    assign accept = req_i & ~ack_q;
    assign wr_en  = accept & bus_req_i.we;

    // --------------------------------------------------
    // handshake, write and read capture
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q       <= 1'b0;
            ctrl_o      <= '0;
            max_acc_o   <= RST_MAX_ACC;
            max_speed_o <= RST_MAX_SPEED;
        end else begin
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!req_i) begin
                ack_q <= 1'b0;
            end
            if (wr_en) begin
                case (bus_req_i.addr)
                    ADR_CONTROL:   ctrl_o      <= ctrl_t'(bus_req_i.wdata[$bits(ctrl_t)-1:0]);
                    ADR_MAX_ACC:   max_acc_o   <= bus_req_i.wdata[Q_W-1:0];
                    ADR_MAX_SPEED: max_speed_o <= bus_req_i.wdata[Q_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read data held for the whole ack phase
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_o <= rdata_next;
        end
    end

    assign ack_o = ack_q;

    // readback mux
    // signed values are sign extended
    always_comb begin
        case (bus_req_i.addr)
            ADR_CORE_ID:   rdata_next = CORE_ID;
            ADR_CONTROL:   rdata_next = {{(DATA_W-$bits(ctrl_t)){1'b0}}, ctrl_o};
            ADR_CUR_ACC:   rdata_next = {{(DATA_W-Q_W){state_i.cur_acc[Q_W-1]}},
                                         state_i.cur_acc};
            ADR_CUR_SPEED: rdata_next = {{(DATA_W-Q_W){state_i.cur_speed[Q_W-1]}},
                                         state_i.cur_speed};
            ADR_CUR_POS:   rdata_next = state_i.cur_pos;
            ADR_MAX_ACC:   rdata_next = {{(DATA_W-Q_W){1'b0}}, max_acc_o};
            ADR_MAX_SPEED: rdata_next = {{(DATA_W-Q_W){1'b0}}, max_speed_o};
            default:       rdata_next = '0;
        endcase
    end

    // writes to the live motion state go out as strobes
    always_comb begin
        wr_o.wr_acc   = wr_en && (bus_req_i.addr == ADR_CUR_ACC);
        wr_o.acc      = bus_req_i.wdata[Q_W-1:0];
        wr_o.wr_speed = wr_en && (bus_req_i.addr == ADR_CUR_SPEED);
        wr_o.speed    = bus_req_i.wdata[Q_W-1:0];
        wr_o.wr_pos   = wr_en && (bus_req_i.addr == ADR_CUR_POS);
        wr_o.pos      = bus_req_i.wdata[POS_W-1:0];
    end

endmodule

// ==== hdl/stepper_pkg.sv ====
package stepper_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int DATA_W = 32;
    localparam int ADDR_W = 4;
    localparam int Q_W    = 16;
    localparam int POS_W  = 16 + Q_W;

    // register map
    localparam logic [ADDR_W-1:0] ADR_CORE_ID   = 4'd0;
    localparam logic [ADDR_W-1:0] ADR_CONTROL   = 4'd2;
    localparam logic [ADDR_W-1:0] ADR_CUR_ACC   = 4'd4;
    localparam logic [ADDR_W-1:0] ADR_CUR_SPEED = 4'd5;
    localparam logic [ADDR_W-1:0] ADR_CUR_POS   = 4'd6;
    localparam logic [ADDR_W-1:0] ADR_MAX_ACC   = 4'd8;
    localparam logic [ADDR_W-1:0] ADR_MAX_SPEED = 4'd9;

    // power-up limits
    localparam logic [Q_W-1:0] RST_MAX_ACC   = 16'd100;
    localparam logic [Q_W-1:0] RST_MAX_SPEED = 16'd100;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    typedef struct packed {
        logic async_update;
        logic nanostep_dis;
        logic microstep_dis;
        logic enable;
    } ctrl_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // host writes into the motion state as one-cycle strobes
    typedef struct packed {
        logic             wr_acc;
        logic [Q_W-1:0]   acc;
        logic             wr_speed;
        logic [Q_W-1:0]   speed;
        logic             wr_pos;
        logic [POS_W-1:0] pos;
    } motion_wr_t;

    typedef struct packed {
        logic [Q_W-1:0]   cur_acc;
        logic [Q_W-1:0]   cur_speed;
        logic [POS_W-1:0] cur_pos;
    } motion_state_t;

endpackage
